// File: rtl/mem_bus_pkg.sv
// memory bus word types
package mem_bus_pkg;

    // data and address share one width on this bus
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

endpackage

// File: rtl/cache_cfg_pkg.sv
// data cache geometry
package cache_cfg_pkg;

    // two ways, eight sets, two-word blocks
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 2;
    localparam int BLOCK_WORDS = 2;

    // address fields, low to high: byte offset, word in block, set, tag
    localparam int IDX_W     = 3;
    localparam int BLKOFF_W  = 1;
    localparam int BYTEOFF_W = 2;
    localparam int TAG_W     = mem_bus_pkg::WORD_W - IDX_W - BLKOFF_W - BYTEOFF_W;

    // frame numbering for the flush walk
    // way 0 sets 0..7 first, then way 1 sets 0..7
    localparam int NUM_FRAMES = NUM_SETS * NUM_WAYS;
    localparam int FRAME_W    = $clog2(NUM_FRAMES);
    localparam logic [FRAME_W-1:0] LAST_FRAME = FRAME_W'(NUM_FRAMES - 1);

    typedef struct packed {
        logic [TAG_W-1:0]     tag;
        logic [IDX_W-1:0]     idx;
        logic [BLKOFF_W-1:0]  blkoff;
        logic [BYTEOFF_W-1:0] byteoff;
    } cache_addr_t;

    typedef struct packed {
        logic                                  valid;
        logic                                  dirty;
        logic [TAG_W-1:0]                      tag;
        mem_bus_pkg::word_t [BLOCK_WORDS-1:0]  data;
    } cache_frame_t;

endpackage

// File: rtl/mem_req_if.sv
// wishbone classic requester link
interface mem_req_if;

    logic               cyc;
    logic               stb;
    logic               we;
    mem_bus_pkg::word_t adr;
    mem_bus_pkg::word_t dat_w;
    mem_bus_pkg::word_t dat_r;
    logic               ack;

    // engine side
    modport requester (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // arbiter side
    modport arbiter (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// File: rtl/cache_store.sv
// data cache frame array
module cache_store (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic                                dmem_ren,
    input  logic                                dmem_wen,
    input  mem_bus_pkg::word_t                  dmem_addr,
    input  mem_bus_pkg::word_t                  dmem_store,
    input  logic                                fill_we,
    input  logic [cache_cfg_pkg::BLKOFF_W-1:0]  fill_word,
    input  mem_bus_pkg::word_t                  fill_data,
    input  logic                                fill_done,
    input  logic [cache_cfg_pkg::FRAME_W-1:0]   flush_sel,
    input  logic                                flush_clean,
    output mem_bus_pkg::word_t                  dmem_load,
    output logic                                dhit,
    output logic                                miss,
    output cache_cfg_pkg::cache_frame_t         victim,
    output cache_cfg_pkg::cache_frame_t         flush_frame
);

    cache_cfg_pkg::cache_addr_t             addr;
    logic [cache_cfg_pkg::NUM_WAYS-1:0]     hit_way;
    logic                                   hit_any;
    logic                                   hw;
    logic                                   req;
    logic                                   wr_hit;
    logic                                   rpl_way;
    logic [cache_cfg_pkg::IDX_W-1:0]        flush_set;
    logic                                   flush_way;

    // state bits per frame
    // the lru bit names the way to replace next
    logic [cache_cfg_pkg::NUM_SETS-1:0][cache_cfg_pkg::NUM_WAYS-1:0] valid_q;
    logic [cache_cfg_pkg::NUM_SETS-1:0][cache_cfg_pkg::NUM_WAYS-1:0] dirty_q;
    logic [cache_cfg_pkg::NUM_SETS-1:0]                             lru_q;

    logic [cache_cfg_pkg::TAG_W-1:0] tag_q
        [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];
    mem_bus_pkg::word_t data_q
        [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS][cache_cfg_pkg::BLOCK_WORDS];
    cache_cfg_pkg::cache_frame_t frames
        [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];

    assign addr    = cache_cfg_pkg::cache_addr_t'(dmem_addr);
    assign req     = dmem_ren || dmem_wen;
    assign rpl_way = lru_q[addr.idx];

    // frame view for the engines
    always_comb begin
        for (int s = 0; s < cache_cfg_pkg::NUM_SETS; s++) begin
            for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
                frames[s][w].valid = valid_q[s][w];
                frames[s][w].dirty = dirty_q[s][w];
                frames[s][w].tag   = tag_q[s][w];
                for (int b = 0; b < cache_cfg_pkg::BLOCK_WORDS; b++) begin
                    frames[s][w].data[b] = data_q[s][w][b];
                end
            end
        end
    end

    // tag compare on both ways of the set
    always_comb begin
        for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
            hit_way[w] = valid_q[addr.idx][w] && (tag_q[addr.idx][w] == addr.tag);
        end
    end

    assign hit_any   = |hit_way;
    assign hw        = hit_way[1];
    assign dhit      = req && hit_any;
    assign miss      = req && !hit_any;
    assign wr_hit    = dmem_wen && hit_any;
    assign dmem_load = data_q[addr.idx][hw][addr.blkoff];

    assign victim      = frames[addr.idx][rpl_way];
    assign flush_set   = flush_sel[cache_cfg_pkg::IDX_W-1:0];
    assign flush_way   = flush_sel[cache_cfg_pkg::FRAME_W-1];
    assign flush_frame = frames[flush_set][flush_way];

    // words and tags
    always_ff @(posedge CLK) begin
        if (wr_hit) begin
            data_q[addr.idx][hw][addr.blkoff] <= dmem_store;
        end
        // fills land in the replacement way
        if (fill_we) begin
            data_q[addr.idx][rpl_way][fill_word] <= fill_data;
        end
        if (fill_done) begin
            tag_q[addr.idx][rpl_way] <= addr.tag;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (wr_hit) begin
                dirty_q[addr.idx][hw] <= 1'b1;
            end
            // point lru at the way not touched
            if (dhit) begin
                lru_q[addr.idx] <= !hw;
            end
            if (fill_done) begin
                valid_q[addr.idx][rpl_way] <= 1'b1;
                dirty_q[addr.idx][rpl_way] <= 1'b0;
            end
            if (flush_clean) begin
                dirty_q[flush_set][flush_way] <= 1'b0;
            end
        end
    end

    // a block sits in at most one way of its set
    a_one_way_hit: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(hit_way));

endmodule

// File: rtl/miss_engine.sv
// miss write-back and fill
module miss_engine (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic                                miss,
    input  mem_bus_pkg::word_t                  dmem_addr,
    input  cache_cfg_pkg::cache_frame_t         victim,
    output logic                                fill_we,
    output logic [cache_cfg_pkg::BLKOFF_W-1:0]  fill_word,
    output mem_bus_pkg::word_t                  fill_data,
    output logic                                fill_done,
    mem_req_if.requester                        bus
);

    typedef enum logic [2:0] {
        IDLE,
        WB0,
        WB1,
        FILL0,
        FILL1
    } state_t;

    state_t                                 state;
    state_t                                 nxt_state;
    cache_cfg_pkg::cache_addr_t             addr;
    cache_cfg_pkg::cache_addr_t             req_addr;
    logic [cache_cfg_pkg::BLKOFF_W-1:0]     word_sel;
    logic                                   wb_phase;

    assign addr = cache_cfg_pkg::cache_addr_t'(dmem_addr);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= nxt_state;
        end
    end

    // each state waits for its ack, cyc stays up to the last fill word
    always_comb begin
        nxt_state = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    nxt_state = victim.dirty ? WB0 : FILL0;
                end
            end
            WB0:     if (bus.ack) nxt_state = WB1;
            WB1:     if (bus.ack) nxt_state = FILL0;
            FILL0:   if (bus.ack) nxt_state = FILL1;
            FILL1:   if (bus.ack) nxt_state = IDLE;
            default: nxt_state = IDLE;
        endcase
    end

    assign wb_phase = (state == WB0) || (state == WB1);
    assign word_sel = (state == WB1) || (state == FILL1);

    // victim block address for write-back, request block for fill
    always_comb begin
        req_addr        = '0;
        req_addr.idx    = addr.idx;
        req_addr.blkoff = word_sel;
        req_addr.tag    = wb_phase ? victim.tag : addr.tag;
    end

    assign bus.cyc   = (state != IDLE);
    assign bus.stb   = (state != IDLE);
    assign bus.we    = wb_phase;
    assign bus.adr   = mem_bus_pkg::word_t'(req_addr);
    assign bus.dat_w = victim.data[word_sel];

    assign fill_we   = ((state == FILL0) || (state == FILL1)) && bus.ack;
    assign fill_word = word_sel;
    assign fill_data = bus.dat_r;
    assign fill_done = (state == FILL1) && bus.ack;

    a_victim_dirty_valid: assert property (@(posedge CLK) disable iff (!nRST)
        victim.dirty |-> victim.valid);

endmodule

// File: rtl/flush_engine.sv
// halt flush of dirty frames
module flush_engine (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic                                halt,
    input  cache_cfg_pkg::cache_frame_t         flush_frame,
    output logic [cache_cfg_pkg::FRAME_W-1:0]   flush_sel,
    output logic                                flush_clean,
    output logic                                flushed,
    mem_req_if.requester                        bus
);

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        WR0,
        WR1
    } state_t;

    state_t                                 state;
    logic [cache_cfg_pkg::FRAME_W-1:0]      cnt;
    logic                                   last;
    logic [cache_cfg_pkg::BLKOFF_W-1:0]     word_sel;
    cache_cfg_pkg::cache_addr_t             wr_addr;

    assign last = (cnt == cache_cfg_pkg::LAST_FRAME);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            cnt     <= '0;
            flushed <= 1'b0;
        end else begin
            case (state)
                IDLE: if (halt && !flushed) state <= SCAN;
                // clean frames cost one cycle
                SCAN: begin
                    if (flush_frame.dirty) begin
                        state <= WR0;
                    end else if (last) begin
                        state   <= IDLE;
                        flushed <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                WR0: if (bus.ack) state <= WR1;
                WR1: begin
                    if (bus.ack && last) begin
                        state   <= IDLE;
                        flushed <= 1'b1;
                    end else if (bus.ack) begin
                        state <= SCAN;
                        cnt   <= cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign word_sel = (state == WR1);

    always_comb begin
        wr_addr        = '0;
        wr_addr.tag    = flush_frame.tag;
        wr_addr.idx    = cnt[cache_cfg_pkg::IDX_W-1:0];
        wr_addr.blkoff = word_sel;
    end

    // one cyc burst per dirty frame
    assign bus.cyc     = (state == WR0) || (state == WR1);
    assign bus.stb     = (state == WR0) || (state == WR1);
    assign bus.we      = 1'b1;
    assign bus.adr     = mem_bus_pkg::word_t'(wr_addr);
    assign bus.dat_w   = flush_frame.data[word_sel];
    assign flush_sel   = cnt;
    assign flush_clean = (state == WR1) && bus.ack;

    // the selected frame stays valid and dirty for its whole burst
    a_burst_dirty: assert property (@(posedge CLK) disable iff (!nRST)
        bus.cyc |-> flush_frame.valid && flush_frame.dirty);

endmodule

// File: rtl/bus_arbiter.sv
// memory bus arbiter
module bus_arbiter (
    input  logic               CLK,
    input  logic               nRST,
    input  mem_bus_pkg::word_t wb_dat_r,
    input  logic               wb_ack,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output mem_bus_pkg::word_t wb_adr,
    output mem_bus_pkg::word_t wb_dat_w,
    mem_req_if.arbiter         miss_bus,
    mem_req_if.arbiter         flush_bus
);

    logic gnt_miss;
    logic gnt_flush;
    logic nxt_gnt_miss;
    logic nxt_gnt_flush;

    // owner keeps the bus while its cyc is up, miss engine wins otherwise
    always_comb begin
        nxt_gnt_miss  = gnt_miss;
        nxt_gnt_flush = gnt_flush;
        if (!(gnt_miss && miss_bus.cyc) && !(gnt_flush && flush_bus.cyc)) begin
            nxt_gnt_miss  = miss_bus.cyc;
            nxt_gnt_flush = !miss_bus.cyc && flush_bus.cyc;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            gnt_miss  <= 1'b0;
            gnt_flush <= 1'b0;
        end else begin
            gnt_miss  <= nxt_gnt_miss;
            gnt_flush <= nxt_gnt_flush;
        end
    end

    always_comb begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        if (gnt_miss) begin
            wb_cyc   = miss_bus.cyc;
            wb_stb   = miss_bus.stb;
            wb_we    = miss_bus.we;
            wb_adr   = miss_bus.adr;
            wb_dat_w = miss_bus.dat_w;
        end else if (gnt_flush) begin
            wb_cyc   = flush_bus.cyc;
            wb_stb   = flush_bus.stb;
            wb_we    = flush_bus.we;
            wb_adr   = flush_bus.adr;
            wb_dat_w = flush_bus.dat_w;
        end
    end

    assign miss_bus.dat_r  = wb_dat_r;
    assign flush_bus.dat_r = wb_dat_r;
    assign miss_bus.ack    = wb_ack && gnt_miss;
    assign flush_bus.ack   = wb_ack && gnt_flush;

    a_gnt_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({gnt_miss, gnt_flush}));

    // memory acks only a granted engine that still holds cyc
    a_ack_owner: assert property (@(posedge CLK) disable iff (!nRST)
        wb_ack |-> (gnt_miss && miss_bus.cyc) || (gnt_flush && flush_bus.cyc));

endmodule

// File: rtl/dcache_top.sv
// two-way write-back data cache
module dcache_top (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               dmem_ren,
    input  logic               dmem_wen,
    input  mem_bus_pkg::word_t dmem_addr,
    input  mem_bus_pkg::word_t dmem_store,
    input  logic               halt,
    input  mem_bus_pkg::word_t wb_dat_r,
    input  logic               wb_ack,
    output mem_bus_pkg::word_t dmem_load,
    output logic               dhit,
    output logic               flushed,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output mem_bus_pkg::word_t wb_adr,
    output mem_bus_pkg::word_t wb_dat_w
);

    logic                                   miss;
    cache_cfg_pkg::cache_frame_t            victim;
    cache_cfg_pkg::cache_frame_t            flush_frame;
    logic                                   fill_we;
    logic [cache_cfg_pkg::BLKOFF_W-1:0]     fill_word;
    mem_bus_pkg::word_t                     fill_data;
    logic                                   fill_done;
    logic [cache_cfg_pkg::FRAME_W-1:0]      flush_sel;
    logic                                   flush_clean;

    // one requester link per engine
    mem_req_if miss_bus ();
    mem_req_if flush_bus ();

    cache_store i_store (
        .CLK         (CLK),
        .nRST        (nRST),
        .dmem_ren    (dmem_ren),
        .dmem_wen    (dmem_wen),
        .dmem_addr   (dmem_addr),
        .dmem_store  (dmem_store),
        .fill_we     (fill_we),
        .fill_word   (fill_word),
        .fill_data   (fill_data),
        .fill_done   (fill_done),
        .flush_sel   (flush_sel),
        .flush_clean (flush_clean),
        .dmem_load   (dmem_load),
        .dhit        (dhit),
        .miss        (miss),
        .victim      (victim),
        .flush_frame (flush_frame)
    );

    miss_engine i_miss (
        .CLK       (CLK),
        .nRST      (nRST),
        .miss      (miss),
        .dmem_addr (dmem_addr),
        .victim    (victim),
        .fill_we   (fill_we),
        .fill_word (fill_word),
        .fill_data (fill_data),
        .fill_done (fill_done),
        .bus       (miss_bus.requester)
    );

    flush_engine i_flush (
        .CLK         (CLK),
        .nRST        (nRST),
        .halt        (halt),
        .flush_frame (flush_frame),
        .flush_sel   (flush_sel),
        .flush_clean (flush_clean),
        .flushed     (flushed),
        .bus         (flush_bus.requester)
    );

    bus_arbiter i_arb (
        .CLK       (CLK),
        .nRST      (nRST),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .miss_bus  (miss_bus.arbiter),
        .flush_bus (flush_bus.arbiter)
    );

endmodule

// File: sim/dcache_checker.sv
// data cache response checker
module dcache_checker (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic                                        dmem_ren,
    input  logic                                        dmem_wen,
    input  mem_bus_pkg::word_t                          dmem_addr,
    input  mem_bus_pkg::word_t                          dmem_store,
    input  mem_bus_pkg::word_t                          dmem_load,
    input  logic                                        dhit,
    input  logic                                        flushed,
    input  logic                                        wb_cyc,
    input  logic                                        wb_stb,
    input  logic                                        wb_we,
    input  mem_bus_pkg::word_t                          wb_adr,
    input  mem_bus_pkg::word_t                          wb_dat_w,
    input  logic                                        wb_ack,
    input  logic [63:0][mem_bus_pkg::WORD_W-1:0]        mem_words,
    output int                                          err_count,
    output int                                          check_count,
    output logic                                        mem_checked
);

    // flat memory of the latest values, plus a two-way residency model
    mem_bus_pkg::word_t              ref_mem [64];
    logic [cache_cfg_pkg::TAG_W-1:0] m_tag [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];
    logic                            m_valid [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];
    logic                            m_lru [cache_cfg_pkg::NUM_SETS];
    logic                            req_open;
    logic                            exp_hit;
    logic                            req_way;
    logic                            prev_stb;
    logic                            prev_ack;
    logic                            prev_we;
    mem_bus_pkg::word_t              prev_adr;
    mem_bus_pkg::word_t              prev_dat;
    logic                            flush_seen;

    initial begin
        err_count   = 0;
        check_count = 0;
        mem_checked = 1'b0;
    end

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
        err_count++;
        $display("error at %0t: %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic plain_error(input string msg);
        err_count++;
        $display("at %0t: %s", $time, msg);
    endtask

    task automatic reset_model();
        for (int s = 0; s < cache_cfg_pkg::NUM_SETS; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
            end
        end
        // memory is untouched while reset is held
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = mem_words[i];
        end
        req_open   = 1'b0;
        prev_stb   = 1'b0;
        prev_ack   = 1'b0;
        flush_seen = 1'b0;
        check_count++;
        if (dhit !== 1'b0) value_error("dhit", 0, dhit);
        if (flushed !== 1'b0) value_error("flushed", 0, flushed);
        if (wb_cyc !== 1'b0) value_error("wb_cyc", 0, wb_cyc);
    endtask

    task automatic check_request();
        cache_cfg_pkg::cache_addr_t a;
        logic [5:0]                 widx;
        a    = cache_cfg_pkg::cache_addr_t'(dmem_addr);
        widx = dmem_addr[7:2];
        if (!(dmem_ren || dmem_wen)) begin
            req_open = 1'b0;
        end else begin
            // hit or miss is decided in the request cycle
            if (!req_open) begin
                exp_hit = 1'b0;
                req_way = m_lru[a.idx];
                for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
                    if (m_valid[a.idx][w] && m_tag[a.idx][w] == a.tag) begin
                        exp_hit = 1'b1;
                        req_way = w[0];
                    end
                end
                check_count++;
                if (dhit !== exp_hit) value_error("dhit", exp_hit, dhit);
            end
            if (dhit) begin
                if (dmem_ren) begin
                    check_count++;
                    if (dmem_load !== ref_mem[widx]) begin
                        value_error("dmem_load", ref_mem[widx], dmem_load);
                    end
                end else begin
                    ref_mem[widx] = dmem_store;
                end
                // a miss fills the lru way, then the hit turns lru away from it
                m_valid[a.idx][req_way] = 1'b1;
                m_tag[a.idx][req_way]   = a.tag;
                m_lru[a.idx]            = !req_way;
                req_open = 1'b0;
            end else begin
                req_open = 1'b1;
            end
        end
    endtask

    task automatic check_bus();
        if (wb_stb && !wb_cyc) plain_error("wishbone stb is high without cyc");
        if (wb_stb && wb_adr[31:8] != '0) plain_error("wishbone address is outside the memory");
        if (flush_seen && wb_cyc && wb_we) plain_error("memory write after flushed");
        // a word without ack must hold everything into the next cycle
        if (prev_stb && !prev_ack) begin
            if (!wb_stb) begin
                plain_error("wishbone stb dropped before ack");
            end else begin
                if (wb_adr !== prev_adr) value_error("wb_adr", prev_adr, wb_adr);
                if (wb_we !== prev_we) value_error("wb_we", prev_we, wb_we);
                if (wb_we && wb_dat_w !== prev_dat) value_error("wb_dat_w", prev_dat, wb_dat_w);
            end
        end
        prev_stb = wb_stb;
        prev_ack = wb_ack;
        prev_we  = wb_we;
        prev_adr = wb_adr;
        prev_dat = wb_dat_w;
    endtask

    task automatic check_flush();
        if (flush_seen && !flushed) value_error("flushed", 1, flushed);
        if (flushed && !flush_seen) begin
            flush_seen = 1'b1;
            for (int i = 0; i < 64; i++) begin
                check_count++;
                if (mem_words[i] !== ref_mem[i]) begin
                    value_error($sformatf("mem[%0d]", i), ref_mem[i], mem_words[i]);
                end
            end
            mem_checked = 1'b1;
        end
    endtask

    // outputs and inputs are both settled at the falling edge
    always @(negedge CLK) begin
        if (!nRST) begin
            reset_model();
        end else begin
            check_flush();
            check_request();
            check_bus();
        end
    end

endmodule

// File: sim/tb_dcache.sv
// data cache testbench
module tb_dcache;

    localparam int RAND_OPS     = 400;
    localparam int DIRECTED_OPS = 6;
    localparam int TOTAL_OPS    = RAND_OPS + DIRECTED_OPS;
    localparam int MEM_WORDS    = 64;
    // dirty miss of four words at up to four cycles each, then the flush
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * 4 * 4
                                  + cache_cfg_pkg::NUM_FRAMES * 2 * 4 + 200;

    logic                                       CLK;
    logic                                       nRST;
    logic                                       dmem_ren;
    logic                                       dmem_wen;
    mem_bus_pkg::word_t                         dmem_addr;
    mem_bus_pkg::word_t                         dmem_store;
    logic                                       halt;
    mem_bus_pkg::word_t                         wb_dat_r;
    logic                                       wb_ack;
    mem_bus_pkg::word_t                         dmem_load;
    logic                                       dhit;
    logic                                       flushed;
    logic                                       wb_cyc;
    logic                                       wb_stb;
    logic                                       wb_we;
    mem_bus_pkg::word_t                         wb_adr;
    mem_bus_pkg::word_t                         wb_dat_w;
    logic [MEM_WORDS-1:0][mem_bus_pkg::WORD_W-1:0] mem;
    int                                         err_count;
    int                                         check_count;
    logic                                       mem_checked;
    int                                         cycle_cnt;

    dcache_top i_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .halt       (halt),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .flushed    (flushed),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w)
    );

    dcache_checker i_checker (
        .CLK         (CLK),
        .nRST        (nRST),
        .dmem_ren    (dmem_ren),
        .dmem_wen    (dmem_wen),
        .dmem_addr   (dmem_addr),
        .dmem_store  (dmem_store),
        .dmem_load   (dmem_load),
        .dhit        (dhit),
        .flushed     (flushed),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_ack      (wb_ack),
        .mem_words   (mem),
        .err_count   (err_count),
        .check_count (check_count),
        .mem_checked (mem_checked)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // one wishbone word with 0 to 3 wait cycles before ack
    task automatic serve_word();
        logic [5:0]         widx;
        logic               we;
        mem_bus_pkg::word_t dat;
        int                 waits;
        widx  = wb_adr[7:2];
        we    = wb_we;
        dat   = wb_dat_w;
        waits = $urandom_range(3, 0);
        repeat (waits) begin
            @(posedge CLK);
            #1;
        end
        wb_dat_r = we ? '0 : mem[widx];
        wb_ack   = 1'b1;
        @(posedge CLK);
        if (we) begin
            mem[widx] = dat;
        end
        #1;
        wb_ack = 1'b0;
    endtask

    // memory slave serving back to back words without a gap
    initial begin
        forever begin
            @(posedge CLK);
            #1;
            while (nRST && wb_cyc && wb_stb) begin
                serve_word();
            end
        end
    end

    // hold the request until the cache answers with dhit
    task automatic cpu_access(input logic wr, input logic [5:0] widx,
                              input mem_bus_pkg::word_t data);
        dmem_ren   = !wr;
        dmem_wen   = wr;
        dmem_addr  = {24'd0, widx, 2'b00};
        dmem_store = data;
        @(negedge CLK);
        while (!dhit) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
    endtask

    initial begin
        int                 i;
        logic               wr;
        logic [5:0]         widx;
        mem_bus_pkg::word_t data;
        void'($urandom(32));
        nRST       = 1'b0;
        dmem_ren   = 1'b0;
        dmem_wen   = 1'b0;
        dmem_addr  = '0;
        dmem_store = '0;
        halt       = 1'b0;
        wb_dat_r   = '0;
        wb_ack     = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5ca1_0000 ^ (i * 32'h0102_0305);
        end
        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(posedge CLK);
        #1;
        // 64 words over 8 sets gives four tags per set
        for (i = 0; i < RAND_OPS; i++) begin
            wr   = $urandom_range(1, 0);
            widx = $urandom_range(63, 0);
            data = $urandom();
            cpu_access(wr, widx, data);
            if ($urandom_range(3, 0) == 0) begin
                @(posedge CLK);
                #1;
            end
        end
        // A B A C in set 5 evicts B so that A hits and B misses
        cpu_access(1'b0, 6'd26, '0);
        cpu_access(1'b0, 6'd42, '0);
        cpu_access(1'b1, 6'd26, 32'hfeed_0a0a);
        cpu_access(1'b0, 6'd58, '0);
        cpu_access(1'b0, 6'd26, '0);
        cpu_access(1'b0, 6'd42, '0);
        halt = 1'b1;
        while (!flushed) begin
            @(negedge CLK);
        end
        repeat (8) @(negedge CLK);
        if (!mem_checked) begin
            $display("memory was never compared after the flush");
        end
        $display("errors: %0d, checks: %0d", err_count, check_count);
        if (err_count == 0 && mem_checked) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: dcache.f
rtl/mem_bus_pkg.sv
rtl/cache_cfg_pkg.sv
rtl/mem_req_if.sv
rtl/cache_store.sv
rtl/miss_engine.sv
rtl/flush_engine.sv
rtl/bus_arbiter.sv
rtl/dcache_top.sv
sim/dcache_checker.sv
sim/tb_dcache.sv
